// ==== hw/rd_guard_defs.svh ====
// ------------------------------
// Read guard sizing macros
// Widths, tracker depth, tick divisor
// ------------------------------
`ifndef RD_GUARD_DEFS_SVH
`define RD_GUARD_DEFS_SVH

// AXI ID width
`define RD_ID_W 4

// AXI address width
`define RD_ADDR_W 32

// AxLEN width, beats = len + 1
`define RD_LEN_W 8

// Tick counter and budget width
`define RD_CNT_W 16

// Outstanding reads held by the tracker
`define RD_MAX_TXNS 4

// Clock cycles per tick
`define RD_PRESCALE_DIV 4

`endif

// ==== hw/rd_guard_pkg.sv ====
// ------------------------------
// Read guard shared types
// Field types, fault causes, queue entry
// ------------------------------
`include "rd_guard_defs.svh"

package rd_guard_pkg;

  typedef logic [`RD_ID_W-1:0]   rd_id_t;
  typedef logic [`RD_ADDR_W-1:0] rd_addr_t;
  typedef logic [`RD_LEN_W-1:0]  rd_len_t;
  typedef logic [`RD_CNT_W-1:0]  rd_cnt_t;

  // One accepted read, oldest first in the tracker
  typedef struct packed {
    rd_id_t   id;
    rd_addr_t addr;
    rd_len_t  len;
    // Absolute tick time for the first R beat
    rd_cnt_t  deadline;
  } rd_txn_t;

  typedef enum logic [2:0] {
    FAULT_NONE       = 3'd0,
    FAULT_AR_STALL   = 3'd1,
    FAULT_FIRST_DATA = 3'd2,
    FAULT_BURST      = 3'd3,
    FAULT_UNEXPECTED = 3'd4
  } rd_fault_e;

endpackage

// ==== hw/rd_prescaler.sv ====
// ------------------------------
// Tick pulse generator and tick time
// ------------------------------
`include "rd_guard_defs.svh"

module rd_prescaler #(
  parameter int unsigned RD_PRESCALE_DIV = `RD_PRESCALE_DIV
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  output logic                  tick_o,
  output rd_guard_pkg::rd_cnt_t now_tick_o
);

  localparam int unsigned DIV_W = (RD_PRESCALE_DIV > 1) ? $clog2(RD_PRESCALE_DIV) : 1;
  localparam logic [DIV_W-1:0] LAST_CYC = DIV_W'(RD_PRESCALE_DIV - 1);

  logic [DIV_W-1:0] cyc_q;

  // Pulse on the last cycle of each division period
  assign tick_o = (cyc_q == LAST_CYC);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc_q      <= '0;
      now_tick_o <= '0;
    end else begin
      if (tick_o) begin
        cyc_q      <= '0;
        // Wraps freely, checkers compare differences only
        now_tick_o <= now_tick_o + 1'b1;
      end else begin
        cyc_q <= cyc_q + 1'b1;
      end
    end
  end

endmodule

// ==== hw/rd_ar_watch.sv ====
// ------------------------------
// AR channel stall timer
// ------------------------------
module rd_ar_watch (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  tick_i,
  input  logic                  flush_i,
  input  logic                  ar_valid_i,
  input  logic                  ar_ready_i,
  input  rd_guard_pkg::rd_cnt_t budget_ar_i,
  output logic                  ar_fault_o
);

  import rd_guard_pkg::*;

  rd_cnt_t stall_cnt_q;
  logic    stalled;

  // Manager waits on the subordinate
  assign stalled = ar_valid_i && !ar_ready_i;

  // The latch flushes us the cycle after, so this stays a single pulse
  assign ar_fault_o = stalled && !flush_i && (stall_cnt_q > budget_ar_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_cnt_q <= '0;
    end else begin
      if (flush_i || !stalled) begin
        stall_cnt_q <= '0;
      end else if (tick_i && (stall_cnt_q != '1)) begin
        // Saturate so a very long stall cannot wrap back under the budget
        stall_cnt_q <= stall_cnt_q + 1'b1;
      end
    end
  end

endmodule

// ==== hw/rd_txn_queue.sv ====
// ------------------------------
// In-order tracker of accepted reads
// Outstanding beat sum, deadline stamping
// ------------------------------
`include "rd_guard_defs.svh"

module rd_txn_queue #(
  parameter int unsigned RD_MAX_TXNS = `RD_MAX_TXNS
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   ar_hs_i,
  input  rd_guard_pkg::rd_id_t   ar_id_i,
  input  rd_guard_pkg::rd_addr_t ar_addr_i,
  input  rd_guard_pkg::rd_len_t  ar_len_i,
  input  rd_guard_pkg::rd_cnt_t  now_tick_i,
  input  rd_guard_pkg::rd_cnt_t  unit_budget_first_i,
  input  logic                   pop_i,
  output logic                   head_valid_o,
  output rd_guard_pkg::rd_txn_t  head_txn_o,
  output logic                   overflow_o
);

  import rd_guard_pkg::*;

  localparam int unsigned PTR_W = (RD_MAX_TXNS > 1) ? $clog2(RD_MAX_TXNS) : 1;
  localparam int unsigned CNT_W = $clog2(RD_MAX_TXNS + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(RD_MAX_TXNS - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(RD_MAX_TXNS);

  rd_txn_t          mem_q [RD_MAX_TXNS];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  rd_cnt_t          beats_q;
  logic             full, enq, deq;
  rd_cnt_t          enq_beats, deq_beats;
  rd_txn_t          new_txn;

  // Pointer wrap also covers depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  assign full         = (count_q == FULL_CNT);
  assign head_valid_o = (count_q != '0);
  assign head_txn_o   = mem_q[rd_ptr_q];

  assign enq        = ar_hs_i && !full && !flush_i;
  assign deq        = pop_i && head_valid_o && !flush_i;
  assign overflow_o = ar_hs_i && full && !flush_i;

  assign enq_beats = rd_cnt_t'(ar_len_i) + 1'b1;
  assign deq_beats = rd_cnt_t'(head_txn_o.len) + 1'b1;

  // First-data budget grows with everything already queued ahead
  assign new_txn.id       = ar_id_i;
  assign new_txn.addr     = ar_addr_i;
  assign new_txn.len      = ar_len_i;
  assign new_txn.deadline = now_tick_i + unit_budget_first_i * (beats_q + enq_beats);

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_q[wr_ptr_q] <= new_txn;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      beats_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      beats_q  <= '0;
    end else begin
      if (enq) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (deq) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({enq, deq})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      beats_q <= beats_q + (enq ? enq_beats : '0) - (deq ? deq_beats : '0);
    end
  end

endmodule

// ==== hw/rd_beat_check.sv ====
// ------------------------------
// Data phase checks on the oldest read
// Deadline, ID, beat count, burst time
// ------------------------------
module rd_beat_check (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  tick_i,
  input  logic                  flush_i,
  input  logic                  r_hs_i,
  input  rd_guard_pkg::rd_id_t  r_id_i,
  input  logic                  r_last_i,
  input  logic                  head_valid_i,
  input  rd_guard_pkg::rd_txn_t head_txn_i,
  input  rd_guard_pkg::rd_cnt_t now_tick_i,
  input  rd_guard_pkg::rd_cnt_t unit_budget_burst_i,
  output logic                  pop_o,
  output logic                  late_o,
  output logic                  burst_late_o,
  output logic                  unexpected_o
);

  import rd_guard_pkg::*;

  localparam int unsigned BUDGET_W = $bits(rd_cnt_t) + $bits(rd_len_t) + 1;

  typedef enum logic {
    WAIT_FIRST,
    IN_BURST
  } rd_phase_e;

  rd_phase_e             phase_q;
  rd_len_t               beat_cnt_q;
  rd_cnt_t               burst_cnt_q;
  rd_cnt_t               since_deadline;
  logic [BUDGET_W-1:0]   burst_budget;
  logic                  id_ok, last_expected, beat_ok;

  // Wrap-safe "now is after deadline"
  assign since_deadline = now_tick_i - head_txn_i.deadline;
  assign burst_budget   = unit_budget_burst_i * ({1'b0, head_txn_i.len} + 1'b1);

  assign id_ok         = head_valid_i && (r_id_i == head_txn_i.id);
  assign last_expected = (beat_cnt_q == head_txn_i.len);
  assign beat_ok       = r_hs_i && id_ok && !flush_i;

  assign late_o = head_valid_i && (phase_q == WAIT_FIRST) && !flush_i &&
                  (since_deadline != '0) && !since_deadline[$bits(rd_cnt_t)-1];
  assign burst_late_o = (phase_q == IN_BURST) && !flush_i &&
                        (BUDGET_W'(burst_cnt_q) > burst_budget);
  // Empty tracker, foreign ID, or RLAST on the wrong beat
  assign unexpected_o = r_hs_i && !flush_i && (!id_ok || (r_last_i != last_expected));
  assign pop_o        = beat_ok && r_last_i && last_expected;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q     <= WAIT_FIRST;
      beat_cnt_q  <= '0;
      burst_cnt_q <= '0;
    end else if (flush_i || pop_o) begin
      phase_q     <= WAIT_FIRST;
      beat_cnt_q  <= '0;
      burst_cnt_q <= '0;
    end else begin
      if (beat_ok) begin
        phase_q    <= IN_BURST;
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
      // Timer starts at the first beat
      if ((phase_q == IN_BURST) && tick_i && (burst_cnt_q != '1)) begin
        burst_cnt_q <= burst_cnt_q + 1'b1;
      end
    end
  end

endmodule

// ==== hw/rd_fault_latch.sv ====
// ------------------------------
// First fault record, IRQ, reset request
// ------------------------------
module rd_fault_latch (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    ar_fault_i,
  input  logic                    overflow_i,
  input  logic                    late_i,
  input  logic                    burst_late_i,
  input  logic                    unexpected_i,
  input  rd_guard_pkg::rd_id_t    ar_id_i,
  input  rd_guard_pkg::rd_addr_t  ar_addr_i,
  input  rd_guard_pkg::rd_txn_t   head_txn_i,
  input  rd_guard_pkg::rd_id_t    r_id_i,
  input  logic                    reset_clear_i,
  output logic                    fault_active_o,
  output rd_guard_pkg::rd_fault_e fault_cause_o,
  output rd_guard_pkg::rd_id_t    fault_id_o,
  output rd_guard_pkg::rd_addr_t  fault_addr_o,
  output logic                    irq_o,
  output logic                    reset_req_o
);

  import rd_guard_pkg::*;

  logic      active_q;
  rd_fault_e cause_d;
  rd_id_t    id_d;
  rd_addr_t  addr_d;

  // Highest priority detect wins
  always_comb begin
    cause_d = FAULT_NONE;
    id_d    = '0;
    addr_d  = '0;
    if (ar_fault_i) begin
      cause_d = FAULT_AR_STALL;
      id_d    = ar_id_i;
      addr_d  = ar_addr_i;
    end else if (late_i || burst_late_i) begin
      cause_d = late_i ? FAULT_FIRST_DATA : FAULT_BURST;
      id_d    = head_txn_i.id;
      addr_d  = head_txn_i.addr;
    end else if (unexpected_i) begin
      cause_d = FAULT_UNEXPECTED;
      id_d    = r_id_i;
      // Head address only when the beat belongs to it
      addr_d  = (r_id_i == head_txn_i.id) ? head_txn_i.addr : '0;
    end else if (overflow_i) begin
      cause_d = FAULT_UNEXPECTED;
      id_d    = ar_id_i;
      addr_d  = ar_addr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q      <= 1'b0;
      fault_cause_o <= FAULT_NONE;
      fault_id_o    <= '0;
      fault_addr_o  <= '0;
    end else if (reset_clear_i) begin
      active_q      <= 1'b0;
      fault_cause_o <= FAULT_NONE;
      fault_id_o    <= '0;
      fault_addr_o  <= '0;
    end else if (!active_q && (cause_d != FAULT_NONE)) begin
      active_q      <= 1'b1;
      fault_cause_o <= cause_d;
      fault_id_o    <= id_d;
      fault_addr_o  <= addr_d;
    end
  end

  // Both held until software clears
  assign fault_active_o = active_q;
  assign irq_o          = active_q;
  assign reset_req_o    = active_q;

endmodule

// ==== hw/rd_guard_top.sv ====
// ------------------------------
// AXI4 read channel guard top level
// ------------------------------
`include "rd_guard_defs.svh"

module rd_guard_top #(
  parameter int unsigned RD_MAX_TXNS     = `RD_MAX_TXNS,
  parameter int unsigned RD_PRESCALE_DIV = `RD_PRESCALE_DIV
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    ar_valid_i,
  input  logic                    ar_ready_i,
  input  rd_guard_pkg::rd_id_t    ar_id_i,
  input  rd_guard_pkg::rd_addr_t  ar_addr_i,
  input  rd_guard_pkg::rd_len_t   ar_len_i,
  input  logic                    r_valid_i,
  input  logic                    r_ready_i,
  input  rd_guard_pkg::rd_id_t    r_id_i,
  input  logic                    r_last_i,
  input  rd_guard_pkg::rd_cnt_t   budget_ar_i,
  input  rd_guard_pkg::rd_cnt_t   unit_budget_first_i,
  input  rd_guard_pkg::rd_cnt_t   unit_budget_burst_i,
  input  logic                    reset_clear_i,
  output logic                    irq_o,
  output logic                    reset_req_o,
  output rd_guard_pkg::rd_fault_e fault_cause_o,
  output rd_guard_pkg::rd_id_t    fault_id_o,
  output rd_guard_pkg::rd_addr_t  fault_addr_o
);

  import rd_guard_pkg::*;

  logic    tick, ar_hs, r_hs, fault_active;
  rd_cnt_t now_tick;
  logic    head_valid, pop;
  rd_txn_t head_txn;
  logic    ar_fault, overflow, late, burst_late, unexpected;

  // Observed transfers
  assign ar_hs = ar_valid_i && ar_ready_i;
  assign r_hs  = r_valid_i && r_ready_i;

  rd_prescaler #(
    .RD_PRESCALE_DIV(RD_PRESCALE_DIV)
  ) i_prescaler (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .tick_o    (tick),
    .now_tick_o(now_tick)
  );

  rd_ar_watch i_ar_watch (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .tick_i     (tick),
    .flush_i    (fault_active),
    .ar_valid_i (ar_valid_i),
    .ar_ready_i (ar_ready_i),
    .budget_ar_i(budget_ar_i),
    .ar_fault_o (ar_fault)
  );

  rd_txn_queue #(
    .RD_MAX_TXNS(RD_MAX_TXNS)
  ) i_txn_queue (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (fault_active),
    .ar_hs_i            (ar_hs),
    .ar_id_i            (ar_id_i),
    .ar_addr_i          (ar_addr_i),
    .ar_len_i           (ar_len_i),
    .now_tick_i         (now_tick),
    .unit_budget_first_i(unit_budget_first_i),
    .pop_i              (pop),
    .head_valid_o       (head_valid),
    .head_txn_o         (head_txn),
    .overflow_o         (overflow)
  );

  rd_beat_check i_beat_check (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .tick_i             (tick),
    .flush_i            (fault_active),
    .r_hs_i             (r_hs),
    .r_id_i             (r_id_i),
    .r_last_i           (r_last_i),
    .head_valid_i       (head_valid),
    .head_txn_i         (head_txn),
    .now_tick_i         (now_tick),
    .unit_budget_burst_i(unit_budget_burst_i),
    .pop_o              (pop),
    .late_o             (late),
    .burst_late_o       (burst_late),
    .unexpected_o       (unexpected)
  );

  rd_fault_latch i_fault_latch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ar_fault_i    (ar_fault),
    .overflow_i    (overflow),
    .late_i        (late),
    .burst_late_i  (burst_late),
    .unexpected_i  (unexpected),
    .ar_id_i       (ar_id_i),
    .ar_addr_i     (ar_addr_i),
    .head_txn_i    (head_txn),
    .r_id_i        (r_id_i),
    .reset_clear_i (reset_clear_i),
    .fault_active_o(fault_active),
    .fault_cause_o (fault_cause_o),
    .fault_id_o    (fault_id_o),
    .fault_addr_o  (fault_addr_o),
    .irq_o         (irq_o),
    .reset_req_o   (reset_req_o)
  );

endmodule

// ==== testbench/tb_rd_guard.sv ====
// ------------------------------
// Testbench for the AXI4 read guard
// AXI drivers, compare tasks, directed tests
// ------------------------------
module tb_rd_guard;

  timeunit 1ns;
  timeprecision 1ps;

  import rd_guard_pkg::*;

  // One tick is four clocks, so one budget of 4 ticks is 16 cycles
  localparam int unsigned BUDGET_CYC = 16;

  logic      clk, rst_n;
  logic      ar_valid, ar_ready, r_valid, r_ready, r_last, reset_clear;
  rd_id_t    ar_id, r_id, fault_id;
  rd_addr_t  ar_addr, fault_addr;
  rd_len_t   ar_len;
  rd_cnt_t   budget_ar, unit_first, unit_burst;
  logic      irq, reset_req;
  rd_fault_e fault_cause;
  logic [31:0] lfsr;
  int        err_cnt, err_base, tests_run, tests_failed;

  rd_guard_top i_dut (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .ar_valid_i         (ar_valid),
    .ar_ready_i         (ar_ready),
    .ar_id_i            (ar_id),
    .ar_addr_i          (ar_addr),
    .ar_len_i           (ar_len),
    .r_valid_i          (r_valid),
    .r_ready_i          (r_ready),
    .r_id_i             (r_id),
    .r_last_i           (r_last),
    .budget_ar_i        (budget_ar),
    .unit_budget_first_i(unit_first),
    .unit_budget_burst_i(unit_burst),
    .reset_clear_i      (reset_clear),
    .irq_o              (irq),
    .reset_req_o        (reset_req),
    .fault_cause_o      (fault_cause),
    .fault_id_o         (fault_id),
    .fault_addr_o       (fault_addr)
  );

  always #10 clk = ~clk;

  // Galois LFSR, taps for x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_cause(input string name, input rd_fault_e got, input rd_fault_e exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_id(input string name, input rd_id_t got, input rd_id_t exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input rd_addr_t got, input rd_addr_t exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  // Address handshake with ARREADY raised together with ARVALID
  task automatic drive_ar(input rd_id_t id, input rd_addr_t addr, input rd_len_t len);
    @(negedge clk);
    ar_valid = 1'b1;
    ar_ready = 1'b1;
    ar_id    = id;
    ar_addr  = addr;
    ar_len   = len;
    @(negedge clk);
    ar_valid = 1'b0;
    ar_ready = 1'b0;
  endtask

  // len + 1 beats, each one cycle, gap idle cycles after each
  task automatic drive_r_burst(input rd_id_t id, input int len, input int gap);
    for (int i = 0; i <= len; i++) begin
      @(negedge clk);
      r_valid = 1'b1;
      r_id    = id;
      r_last  = (i == len);
      @(negedge clk);
      r_valid = 1'b0;
      r_last  = 1'b0;
      repeat (gap) @(negedge clk);
    end
  endtask

  task automatic wait_irq(input int max_cycles);
    int n;
    n = 0;
    while (!irq && (n < max_cycles)) begin
      @(negedge clk);
      n++;
    end
    if (!irq) begin
      $display("Timeout: irq_o stayed low for %0d cycles", max_cycles);
      err_cnt++;
    end
  endtask

  task automatic check_clean();
    check_bit("irq_o", irq, 1'b0);
    check_bit("reset_req_o", reset_req, 1'b0);
    check_cause("fault_cause_o", fault_cause, FAULT_NONE);
  endtask

  task automatic clear_fault();
    @(negedge clk);
    reset_clear = 1'b1;
    @(negedge clk);
    reset_clear = 1'b0;
    check_clean();
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (err_cnt == err_base) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, err_cnt - err_base);
    end
    err_base = err_cnt;
  endtask

  task automatic reset_values();
    check_clean();
    report_test("reset values");
  endtask

  // Lengths 3, 1, 0 in flight, third AR lands on the same edge as the first pop
  task automatic in_order_reads();
    logic [31:0] v;
    rd_id_t      id [3];
    rd_addr_t    addr [3];
    int          len [3];
    len = '{3, 1, 0};
    for (int i = 0; i < 3; i++) begin
      rand_bits($bits(rd_id_t), v);
      id[i] = rd_id_t'(v);
      rand_bits($bits(rd_addr_t), v);
      addr[i] = v;
    end
    drive_ar(id[0], addr[0], rd_len_t'(len[0]));
    drive_ar(id[1], addr[1], rd_len_t'(len[1]));
    fork
      begin
        for (int i = 0; i < 3; i++) begin
          drive_r_burst(id[i], len[i], 1);
        end
      end
      begin
        repeat (9) @(negedge clk);
        drive_ar(id[2], addr[2], rd_len_t'(len[2]));
      end
    join
    // Long enough for any stuck entry to miss its deadline
    repeat (130) @(negedge clk);
    check_clean();
    report_test("in-order reads");
  endtask

  task automatic ar_stall();
    logic [31:0] v;
    rd_id_t      id;
    rd_addr_t    addr;
    rand_bits($bits(rd_id_t), v);
    id = rd_id_t'(v);
    rand_bits($bits(rd_addr_t), v);
    addr = v;
    @(negedge clk);
    ar_valid = 1'b1;
    ar_ready = 1'b0;
    ar_id    = id;
    ar_addr  = addr;
    ar_len   = '0;
    wait_irq(10 * BUDGET_CYC);
    check_cause("fault_cause_o", fault_cause, FAULT_AR_STALL);
    check_id("fault_id_o", fault_id, id);
    check_addr("fault_addr_o", fault_addr, addr);
    check_bit("irq_o", irq, 1'b1);
    check_bit("reset_req_o", reset_req, 1'b1);
    ar_valid = 1'b0;
    clear_fault();
    report_test("AR stall");
  endtask

  task automatic first_data_late();
    logic [31:0] v;
    rd_id_t      id;
    rd_addr_t    addr;
    rand_bits($bits(rd_id_t), v);
    id = rd_id_t'(v);
    rand_bits($bits(rd_addr_t), v);
    addr = v;
    // Two beats give a first-data budget of 8 ticks
    drive_ar(id, addr, 8'd1);
    wait_irq(5 * 2 * BUDGET_CYC);
    check_cause("fault_cause_o", fault_cause, FAULT_FIRST_DATA);
    check_id("fault_id_o", fault_id, id);
    check_addr("fault_addr_o", fault_addr, addr);
    clear_fault();
    report_test("first data late");
  endtask

  task automatic burst_too_long();
    logic [31:0] v;
    rd_id_t      id;
    rd_addr_t    addr;
    rand_bits($bits(rd_id_t), v);
    id = rd_id_t'(v);
    rand_bits($bits(rd_addr_t), v);
    addr = v;
    drive_ar(id, addr, 8'd3);
    // First to last is 141 cycles, budget is 4 x 4 ticks = 64 cycles
    drive_r_burst(id, 3, 45);
    wait_irq(4 * BUDGET_CYC);
    check_cause("fault_cause_o", fault_cause, FAULT_BURST);
    check_id("fault_id_o", fault_id, id);
    check_addr("fault_addr_o", fault_addr, addr);
    clear_fault();
    report_test("burst too long");
  endtask

  task automatic unexpected_beats();
    logic [31:0] v;
    rd_id_t      id;
    rd_addr_t    addr;
    rand_bits($bits(rd_id_t), v);
    id = rd_id_t'(v);
    drive_r_burst(id, 0, 0);
    wait_irq(4 * BUDGET_CYC);
    check_cause("fault_cause_o", fault_cause, FAULT_UNEXPECTED);
    check_id("fault_id_o", fault_id, id);
    clear_fault();
    rand_bits($bits(rd_id_t), v);
    id = rd_id_t'(v);
    rand_bits($bits(rd_addr_t), v);
    addr = v;
    drive_ar(id, addr, 8'd0);
    drive_r_burst(id ^ rd_id_t'(1), 0, 0);
    wait_irq(4 * BUDGET_CYC);
    check_cause("fault_cause_o", fault_cause, FAULT_UNEXPECTED);
    check_id("fault_id_o", fault_id, id ^ rd_id_t'(1));
    clear_fault();
    report_test("unexpected beats");
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    ar_valid     = 1'b0;
    ar_ready     = 1'b0;
    ar_id        = '0;
    ar_addr      = '0;
    ar_len       = '0;
    r_valid      = 1'b0;
    r_ready      = 1'b1;
    r_id         = '0;
    r_last       = 1'b0;
    budget_ar    = 16'd4;
    unit_first   = 16'd4;
    unit_burst   = 16'd4;
    reset_clear  = 1'b0;
    lfsr         = 32'h4c64eb4a;
    err_cnt      = 0;
    err_base     = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    reset_values();
    in_order_reads();
    ar_stall();
    first_data_late();
    burst_too_long();
    unexpected_beats();
    $display("Summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+hw
hw/rd_guard_pkg.sv
hw/rd_prescaler.sv
hw/rd_ar_watch.sv
hw/rd_txn_queue.sv
hw/rd_beat_check.sv
hw/rd_fault_latch.sv
hw/rd_guard_top.sv
testbench/tb_rd_guard.sv

// ==== Bender.yml ====
package:
  name: rd_guard

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/rd_guard_pkg.sv
      - hw/rd_prescaler.sv
      - hw/rd_ar_watch.sv
      - hw/rd_txn_queue.sv
      - hw/rd_beat_check.sv
      - hw/rd_fault_latch.sv
      - hw/rd_guard_top.sv
      - target: test
        files:
          - testbench/tb_rd_guard.sv
